// ==== bench/thorDecodeTb.sv ====
`timescale 1ns/1ps
`include "thorDecode_cfg.svh"

module thorDecodeTb;
	import thorDecodePkg::*;

	localparam int PERIOD = 100;
	localparam int MAXROWS = 64;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	instruction_t inInstr;
	logic outValid;
	logic outReady;
	logic outLoad;
	logic [1:0] outSize;
	logic outSigned;
	logic [`THOR_RWIDTH-1:0] outRd;
	logic [`THOR_RWIDTH-1:0] outRs1;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [`THOR_CWIDTH-1:0] datI;
	logic [`THOR_CWIDTH-1:0] datO;
	logic ack;

	// One row per vector, the word on top and one hex digit each for load, size, sign
	logic [`THOR_IWIDTH+11:0] tests [0:MAXROWS-1];
	int rowCount = 0;
	int expLoads;
	int outIdx;
	int seed;
	int errorCount;
	int testCount;
	int failedTests;
	int testStartErrors;

	thorDecode dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// Stops a run that hangs on a handshake, scaled by the number of vectors
	// The row count is known well before reset is released
	initial
	begin
		@(negedge reset);
		#((rowCount * 20 + 200) * PERIOD);
		$display("Timeout after %0d clock periods, a handshake never completed",
			rowCount * 20 + 200);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			errorCount++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic checkSize(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
		begin
			errorCount++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic checkWord(input string name, input logic [`THOR_CWIDTH-1:0] exp,
		input logic [`THOR_CWIDTH-1:0] act);
		if (act !== exp)
		begin
			errorCount++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Only Rd and Rs1 are filled in, so the whole word compares those two fields
	task automatic checkInstr(input string name, input instruction_t exp, input instruction_t act);
		if (act !== exp)
		begin
			errorCount++;
			$display("FAILED %s: expected rd %0d rs1 %0d, actual rd %0d rs1 %0d", name,
				exp.lsn.rd, exp.lsn.rs1, act.lsn.rd, act.lsn.rs1);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount != testStartErrors)
		begin
			failedTests++;
			$display("%s: failed", name);
		end
		else
			$display("%s: passed", name);
		testStartErrors = errorCount;
	endtask

	// ==============================
	// Wishbone master
	// ==============================

	// Request goes out on an edge and drops on the edge after ack was seen
	task automatic busWrite(input logic [1:0] addr, input logic [`THOR_CWIDTH-1:0] data);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= addr;
		datI <= data;
		do @(negedge clk); while (!ack);
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic busRead(input logic [1:0] addr, output logic [`THOR_CWIDTH-1:0] data);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= addr;
		do @(negedge clk); while (!ack);
		data = datO;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	// Expected fields come from the vector and from the lsn field positions
	task automatic checkRow(input int idx);
		logic [`THOR_IWIDTH+11:0] row;
		instruction_t word;
		instruction_t expRegs;
		instruction_t actRegs;
		row = tests[idx];
		word = row[`THOR_IWIDTH+11:12];
		expRegs = '0;
		expRegs.lsn.rd = word.lsn.rd;
		expRegs.lsn.rs1 = word.lsn.rs1;
		actRegs = '0;
		actRegs.lsn.rd = outRd;
		actRegs.lsn.rs1 = outRs1;
		checkBit($sformatf("row %0d load", idx), row[8], outLoad);
		checkSize($sformatf("row %0d size", idx), row[5:4], outSize);
		checkBit($sformatf("row %0d sign", idx), row[0], outSigned);
		checkInstr($sformatf("row %0d registers", idx), expRegs, actRegs);
		finishTest($sformatf("row %0d", idx));
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		int rows;
		int loads;
		logic [`THOR_CWIDTH-1:0] word;
		seed = 74;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		testStartErrors = 0;
		outIdx = 0;
		reset = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		outReady = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datI = '0;
		$readmemh("bench/thorDecode_tests.txt", tests);
		// Rows end at the first entry the file left unwritten
		rows = 0;
		loads = 0;
		while (rows < MAXROWS && !$isunknown(tests[rows]))
		begin
			loads += tests[rows][8];
			rows++;
		end
		expLoads = loads;
		rowCount = rows;
		if (rowCount == 0)
		begin
			errorCount++;
			$display("No test vectors could be read from the data file");
		end

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkBit("reset outValid", 1'b0, outValid);
		checkBit("reset inReady", 1'b0, inReady);
		checkBit("reset ack", 1'b0, ack);
		busRead(2'd0, word);
		checkWord("reset CTRL", '0, word);
		busRead(2'd1, word);
		checkWord("reset INSTCNT", '0, word);
		busRead(2'd2, word);
		checkWord("reset LOADCNT", '0, word);
		finishTest("reset state");

		// Stream every vector while the sink stalls about one cycle in four
		busWrite(2'd0, 32'd1);
		fork
			begin
				for (int i = 0; i < rowCount; i++)
				begin
					@(posedge clk);
					inValid <= 1'b1;
					inInstr <= tests[i][`THOR_IWIDTH+11:12];
					do @(negedge clk); while (!inReady);
				end
				@(posedge clk);
				inValid <= 1'b0;
			end
			while (outIdx < rowCount)
			begin
				@(negedge clk);
				if (outValid && outReady)
				begin
					checkRow(outIdx);
					outIdx++;
				end
			end
			while (outIdx < rowCount)
			begin
				@(posedge clk);
				outReady <= ($random(seed) & 3) != 0;
			end
		join
		@(posedge clk);
		outReady <= 1'b1;
		repeat (3) @(negedge clk);
		checkBit("stream drained", 1'b0, outValid);
		finishTest("stream order");

		// With decoding off a waiting item must stay outside the stage
		busWrite(2'd0, 32'd0);
		@(posedge clk);
		inValid <= 1'b1;
		inInstr <= tests[0][`THOR_IWIDTH+11:12];
		repeat (5)
		begin
			@(negedge clk);
			checkBit("disabled inReady", 1'b0, inReady);
		end
		checkBit("disabled outValid", 1'b0, outValid);
		@(posedge clk);
		inValid <= 1'b0;
		finishTest("disable");

		busRead(2'd1, word);
		checkWord("INSTCNT", rowCount, word);
		busRead(2'd2, word);
		checkWord("LOADCNT", expLoads, word);
		finishTest("counters");

		// Enable stays set, the clear bit is a strobe
		busWrite(2'd0, 32'd3);
		busRead(2'd0, word);
		checkWord("CTRL after clear", 32'd1, word);
		busRead(2'd1, word);
		checkWord("INSTCNT after clear", '0, word);
		busRead(2'd2, word);
		checkWord("LOADCNT after clear", '0, word);
		busRead(2'd3, word);
		checkWord("unused address", '0, word);
		finishTest("clear");

		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== bench/thorDecode_chk.sv ====
`timescale 1ns/1ps
`include "thorDecode_cfg.svh"

module thorDecode_chk (
	input logic clk,
	input logic reset,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic outLoad,
	input logic [1:0] outSize,
	input logic outSigned,
	input logic [`THOR_RWIDTH-1:0] outRd,
	input logic [`THOR_RWIDTH-1:0] outRs1,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic enable
);

	// ==============================
	// Bus and stream rules
	// ==============================

	// Ack only answers a request seen at the previous edge
	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(cyc && stb))
		else $error("ack rose without cyc and stb in the cycle before");

	// A stalled item stays valid and keeps every field
	heldWhileStalled: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid
		&& $stable({outLoad, outSize, outSigned, outRd, outRs1}))
		else $error("decoded output changed while stalled");

	// No item may enter while decoding is switched off
	readyNeedsEnable: assert property (@(posedge clk) disable iff (reset)
		!enable |-> !inReady)
		else $error("inReady high while enable is low");

endmodule

bind thorDecode thorDecode_chk chk0 (
	.clk(clk),
	.reset(reset),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.outLoad(outLoad),
	.outSize(outSize),
	.outSigned(outSigned),
	.outRd(outRd),
	.outRs1(outRs1),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.enable(stats0.enable)
);

// ==== bench/thorDecode_tests.txt ====
// Each row is instruction_load_size_sign, with the 40-bit word in ten hex digits
// Load flag, size code and sign then take one hex digit each
00000040C0_1_0_1 // LDB rd 1 rs1 2
00000081C1_1_0_0 // LDBU rd 3 rs1 4
000000C2C2_1_1_1 // LDW rd 5 rs1 6
00000103C3_1_1_0 // LDWU rd 7 rs1 8
00000144C4_1_2_1 // LDT rd 9 rs1 10
000007FFC5_1_2_0 // LDTU rd 63 rs1 63
0091A185C6_1_3_1 // LDO rd 11 rs1 12 disp 1234
3000006147_1_2_1 // LDX func 6 gives signed tetra
080000A247_1_1_0 // LDX func 1 gives unsigned wyde
38000020C7_1_3_1 // LDX func 7 gives signed octa
F80000E347_0_3_1 // LDX with func LDAX is no load
F800012440_0_0_1 // LDB with func LDAX is no load
0000016502_0_0_0 // opcode 2 is outside the load group
F80001A648_0_0_0 // opcode 72 sits just above LDX
0000054ABF_0_0_0 // opcode 63 sits just below LDB
87FFF9C6C2_1_1_1 // LDW with func 16 and full displacement

// ==== logic/decodeLoad.sv ====
`timescale 1ns/1ps

module decodeLoad (
	input thorDecodePkg::instruction_t instr,
	output logic load
);
	import thorDecodePkg::*;

	// ==============================
	// Load detection
	// ==============================

	// Every load opcode counts as a load unless func marks it as LDAX
	// LDAX only forms an address, so no memory read follows
	always_comb
	begin
		case (instr.any.opcode)
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO, OP_LDX:
			begin
				if (instr.lsn.func == FN_LDAX)
					load = 1'b0;
				else
					load = 1'b1;
			end
			// Anything outside the load group is not a load
			default:
				load = 1'b0;
		endcase
	end

endmodule

// ==== logic/decodeMemSize.sv ====
`timescale 1ns/1ps

module decodeMemSize (
	input thorDecodePkg::instruction_t instr,
	output logic [1:0] size,
	output logic isSigned
);
	import thorDecodePkg::*;

	// ==============================
	// Size and sign from the opcode
	// ==============================

	// Signed forms sign extend the loaded value, the U forms zero extend
	// LDX carries its size in func bits 1..0 and its sign in func bit 2
	always_comb
	begin
		case (instr.any.opcode)
			OP_LDB:  begin size = SZ_BYTE;  isSigned = 1'b1; end
			OP_LDBU: begin size = SZ_BYTE;  isSigned = 1'b0; end
			OP_LDW:  begin size = SZ_WYDE;  isSigned = 1'b1; end
			OP_LDWU: begin size = SZ_WYDE;  isSigned = 1'b0; end
			OP_LDT:  begin size = SZ_TETRA; isSigned = 1'b1; end
			OP_LDTU: begin size = SZ_TETRA; isSigned = 1'b0; end
			// Octa fills the whole register, treated as signed
			OP_LDO:  begin size = SZ_OCTA;  isSigned = 1'b1; end
			OP_LDX:
			begin
				size = instr.lsn.func[1:0];
				isSigned = instr.lsn.func[2];
			end
			// Non-load opcodes report a byte, unsigned
			default:
			begin
				size = SZ_BYTE;
				isSigned = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/decodeRegs.sv ====
`timescale 1ns/1ps
`include "thorDecode_cfg.svh"

module decodeRegs (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [1:0] adr,
	input logic [`THOR_CWIDTH-1:0] datI,
	output logic [`THOR_CWIDTH-1:0] datO,
	output logic ack,
	decodeStatsIf.regs stats
);

	// Word addresses of the register map
	localparam logic [1:0] ADR_CTRL = 2'd0;
	localparam logic [1:0] ADR_INSTCNT = 2'd1;
	localparam logic [1:0] ADR_LOADCNT = 2'd2;

	// First cycle of a bus access, the edge that ends it is the access edge
	logic access;
	// Write to CTRL in this access
	logic ctrlWrite;
	logic enableBit;
	logic [`THOR_CWIDTH-1:0] instCnt;
	logic [`THOR_CWIDTH-1:0] loadCnt;
	logic [`THOR_CWIDTH-1:0] readData;

	// ==============================
	// Wishbone classic handshake
	// ==============================

	// Ack follows cyc and stb by one cycle and drops the cycle after
	assign access = cyc & stb & ~ack;
	assign ctrlWrite = access & we & (adr == ADR_CTRL);

	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= access;
	end

	// Register map read mux
	// CTRL bit 1 is a strobe and always reads back as zero
	always_comb
	begin
		readData = '0;
		case (adr)
			ADR_CTRL:
				readData[0] = enableBit;
			ADR_INSTCNT:
				readData = instCnt;
			ADR_LOADCNT:
				readData = loadCnt;
			// Address 3 is unused and reads zero
			default:
				readData = '0;
		endcase
	end

	// Read data is captured at the access edge and shown while ack is high
	always_ff @(posedge clk)
	begin
		if (access)
			datO <= readData;
	end

	// ==============================
	// Control and counters
	// ==============================

	// Only CTRL is writable, writes elsewhere fall through unused
	always_ff @(posedge clk)
	begin
		if (reset)
			enableBit <= 1'b0;
		else if (ctrlWrite)
			enableBit <= datI[0];
	end

	assign stats.enable = enableBit;
	assign stats.clearCounts = ctrlWrite & datI[1];

	// Clear wins over a coinciding event so the counter lands on zero
	always_ff @(posedge clk)
	begin
		if (reset || stats.clearCounts)
		begin
			instCnt <= '0;
			loadCnt <= '0;
		end
		else
		begin
			if (stats.accepted)
				instCnt <= instCnt + 1'b1;
			if (stats.acceptedLoad)
				loadCnt <= loadCnt + 1'b1;
		end
	end

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`include "thorDecode_cfg.svh"

module decodeStage (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input thorDecodePkg::instruction_t inInstr,
	output logic outValid,
	input logic outReady,
	output logic outLoad,
	output logic [1:0] outSize,
	output logic outSigned,
	output logic [`THOR_RWIDTH-1:0] outRd,
	output logic [`THOR_RWIDTH-1:0] outRs1,
	decodeStatsIf.stage stats
);

	// Transfer into the stage in this cycle
	logic accept;
	// Decoder results for the word on the input
	logic isLoad;
	logic [1:0] memSize;
	logic memSigned;

	// ==============================
	// Decoders on the input word
	// ==============================

	decodeLoad load0 (
		.instr(inInstr),
		.load(isLoad)
	);

	decodeMemSize size0 (
		.instr(inInstr),
		.size(memSize),
		.isSigned(memSigned)
	);

	// The single slot is free when empty or when its item leaves this cycle
	// Ready passes straight through so the stage streams one item per cycle
	assign inReady = stats.enable & (~outValid | outReady);
	assign accept = inValid & inReady;

	// Events line up with the edge that loads the output register
	assign stats.accepted = accept;
	assign stats.acceptedLoad = accept & isLoad;

	// ==============================
	// Stage register
	// ==============================

	// Valid is control state and is cleared by reset
	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else if (accept)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	// Decoded fields only change on acceptance, so a stalled item holds steady
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			outLoad <= isLoad;
			outSize <= memSize;
			outSigned <= memSigned;
			outRd <= inInstr.lsn.rd;
			outRs1 <= inInstr.lsn.rs1;
		end
	end

endmodule

// ==== logic/decodeStatsIf.sv ====
`timescale 1ns/1ps

// Control and event lines between the decode stage and the register block
interface decodeStatsIf;

	// Decoding is allowed while this is high
	logic enable;
	// High in each cycle an item is taken into the stage
	logic accepted;
	// High together with accepted when that item is a load
	logic acceptedLoad;
	// Single cycle request to zero both counters
	logic clearCounts;

	// The register block owns control and counts the events
	modport regs (output enable, output clearCounts, input accepted, input acceptedLoad);

	// The stage obeys enable and reports what it takes in
	modport stage (input enable, output accepted, output acceptedLoad);

endinterface

// ==== logic/thorDecode.sv ====
`timescale 1ns/1ps
`include "thorDecode_cfg.svh"

module thorDecode (
	input logic clk,
	input logic reset,
	// Instruction stream in
	input logic inValid,
	output logic inReady,
	input thorDecodePkg::instruction_t inInstr,
	// Decoded stream out
	output logic outValid,
	input logic outReady,
	output logic outLoad,
	output logic [1:0] outSize,
	output logic outSigned,
	output logic [`THOR_RWIDTH-1:0] outRd,
	output logic [`THOR_RWIDTH-1:0] outRs1,
	// Wishbone classic slave
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [1:0] adr,
	input logic [`THOR_CWIDTH-1:0] datI,
	output logic [`THOR_CWIDTH-1:0] datO,
	output logic ack
);

	// ==============================
	// Stage and register block
	// ==============================

	// Enable, event pulses and the clear strobe run through here
	decodeStatsIf stats0 ();

	decodeStage stage0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.outValid(outValid),
		.outReady(outReady),
		.outLoad(outLoad),
		.outSize(outSize),
		.outSigned(outSigned),
		.outRd(outRd),
		.outRs1(outRs1),
		.stats(stats0.stage)
	);

	// Host side view of enable and the counts
	decodeRegs regs0 (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datI(datI),
		.datO(datO),
		.ack(ack),
		.stats(stats0.regs)
	);

endmodule

// ==== logic/thorDecodePkg.sv ====
`include "thorDecode_cfg.svh"

package thorDecodePkg;

	// ==============================
	// Load opcodes
	// ==============================

	// Signed and unsigned loads come in pairs, octa has no unsigned form
	localparam logic [`THOR_OWIDTH-1:0] OP_LDB  = 7'd64;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDBU = 7'd65;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDW  = 7'd66;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDWU = 7'd67;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDT  = 7'd68;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDTU = 7'd69;
	localparam logic [`THOR_OWIDTH-1:0] OP_LDO  = 7'd70;
	// Indexed load, size and sign come from the func field
	localparam logic [`THOR_OWIDTH-1:0] OP_LDX  = 7'd71;

	// Load address only, computes the address and reads no memory
	localparam logic [`THOR_FWIDTH-1:0] FN_LDAX = 5'd31;

	// ==============================
	// Memory access size codes
	// ==============================

	localparam logic [1:0] SZ_BYTE  = 2'd0;
	localparam logic [1:0] SZ_WYDE  = 2'd1;
	localparam logic [1:0] SZ_TETRA = 2'd2;
	localparam logic [1:0] SZ_OCTA  = 2'd3;

	// One instruction word seen two ways
	// The any view only splits off the opcode, the lsn view names the load fields
	typedef union packed
	{
		struct packed
		{
			logic [`THOR_IWIDTH-`THOR_OWIDTH-1:0] payload;
			logic [`THOR_OWIDTH-1:0] opcode;
		} any;
		struct packed
		{
			logic [`THOR_FWIDTH-1:0] func;
			// Displacement takes whatever is left between func and Rs1
			logic [`THOR_IWIDTH-`THOR_FWIDTH-2*`THOR_RWIDTH-`THOR_OWIDTH-1:0] disp;
			logic [`THOR_RWIDTH-1:0] rs1;
			logic [`THOR_RWIDTH-1:0] rd;
			logic [`THOR_OWIDTH-1:0] opcode;
		} lsn;
	} instruction_t;

endpackage

// ==== logic/thorDecode_cfg.svh ====
`ifndef THORDECODE_CFG_SVH
`define THORDECODE_CFG_SVH

// ==============================
// Decode slice sizing
// ==============================

// Width of one fetched instruction word
`define THOR_IWIDTH 40

// Width of a register number field
// Rd and Rs1 both use this width in the lsn view
`define THOR_RWIDTH 6

// Width of each event counter
// The Wishbone data bus is the same width so a counter reads in one access
`define THOR_CWIDTH 32

// Opcode field width, fixed by the instruction set
`define THOR_OWIDTH 7

// Function field width at the top of a load word
`define THOR_FWIDTH 5

`endif

// ==== thorDecode.f ====
+incdir+logic
logic/thorDecodePkg.sv
logic/decodeStatsIf.sv
logic/decodeLoad.sv
logic/decodeMemSize.sv
logic/decodeStage.sv
logic/decodeRegs.sv
logic/thorDecode.sv
bench/thorDecode_chk.sv
bench/thorDecodeTb.sv
